//--- rtl/gfx_mem_pkg.sv
/*
 * Video memory types shared by the graphics command front end.
 * Covers word addresses, pixel words and the write request bundle.
 */

package gfx_mem_pkg;

    // Word address into video memory
    typedef logic [31:0] vram_addr_t;

    // One memory word, colour or depth
    typedef logic [15:0] pixel_t;

    // Write request, held until acknowledged
    typedef struct packed {
        logic       select;
        logic       write;
        vram_addr_t address;
        pixel_t     data;
    } vram_req_t;

endpackage

//--- rtl/gfx_cmd_pkg.sv
/*
 * Command stream definitions for the graphics command front end.
 * Holds the command word layout, the opcodes and the command FSM states.
 */

package gfx_cmd_pkg;

    // Opcodes still handled, anything else is dropped
    typedef enum logic [7:0] {
        OP_CLEAR        = 8'd1,
        OP_SWAP         = 8'd2,
        OP_SET_TEX_ADDR = 8'd3,
        OP_WRITE_TEX    = 8'd4
    } opcode_e;

    // Select picks the high half for addresses, depth for clear
    typedef struct packed {
        logic [7:0]  opcode;
        logic [6:0]  reserved;
        logic        select;
        logic [15:0] payload;
    } cmd_word_t;

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        FILL,
        TEX_WRITE,
        SWAP_WAIT
    } cmd_state_e;

endpackage

//--- rtl/vram_writer.sv
/*
 * Video memory writer. Writes one data word to a run of consecutive
 * addresses, each write held until acknowledged.
 */

`timescale 1ns/1ns

module vram_writer (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    start_i,
    input  gfx_mem_pkg::vram_addr_t addr_i,
    input  gfx_mem_pkg::vram_addr_t count_i,
    input  gfx_mem_pkg::pixel_t     data_i,
    output logic                    busy_o,
    output gfx_mem_pkg::vram_req_t  vram_req_o,
    input  logic                    vram_ack_i
);
    import gfx_mem_pkg::*;

    typedef enum logic [1:0] {
        W_IDLE,
        W_WRITE,
        W_GAP
    } wr_state_e;

    wr_state_e  state_q;
    vram_addr_t addr_q;
    vram_addr_t remaining_q;
    pixel_t     data_q;
    logic       load;
    logic       last_word;

    assign load = (state_q == W_IDLE) && start_i;

    // A zero count still writes a single word
    assign last_word = (remaining_q <= vram_addr_t'(1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q     <= W_IDLE;
            remaining_q <= '0;
        end else begin
            case (state_q)
                W_IDLE: begin
                    if (start_i) begin
                        state_q     <= W_WRITE;
                        remaining_q <= count_i;
                    end
                end

                W_WRITE: begin
                    if (vram_ack_i) begin
                        if (last_word) begin
                            state_q <= W_IDLE;
                        end else begin
                            state_q     <= W_GAP;
                            remaining_q <= remaining_q - vram_addr_t'(1);
                        end
                    end
                end

                // Select low for one cycle between words
                W_GAP: state_q <= W_WRITE;

                default: state_q <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            addr_q <= addr_i;
            data_q <= data_i;
        end else if (state_q == W_GAP) begin
            addr_q <= addr_q + vram_addr_t'(1);
        end
    end

    assign busy_o = (state_q != W_IDLE);

    always_comb begin
        vram_req_o.select  = (state_q == W_WRITE);
        vram_req_o.write   = (state_q == W_WRITE);
        vram_req_o.address = addr_q;
        vram_req_o.data    = data_q;
    end

endmodule

//--- rtl/buffer_swap.sv
/*
 * Front and back buffer exchange, optionally held off until vsync.
 * Keeps swap and busy up after an exchange until vsync is seen.
 */

`timescale 1ns/1ns

module buffer_swap #(
    parameter int FB_WIDTH  = 128,
    parameter int FB_HEIGHT = 128
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    swap_req_i,
    input  logic                    wait_vsync_i,
    input  logic                    vsync_i,
    output logic                    swap_o,
    output logic                    busy_o,
    output gfx_mem_pkg::vram_addr_t front_addr_o,
    output gfx_mem_pkg::vram_addr_t back_addr_o
);
    import gfx_mem_pkg::*;

    localparam vram_addr_t FRAME_SIZE = vram_addr_t'(FB_WIDTH * FB_HEIGHT);

    logic pending_q;
    logic swap_q;
    logic exchange;

    // New request goes straight through unless it has to wait for vsync
    assign exchange = (swap_req_i && (!wait_vsync_i || vsync_i)) || (pending_q && vsync_i);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pending_q    <= 1'b0;
            swap_q       <= 1'b0;
            front_addr_o <= '0;
            back_addr_o  <= FRAME_SIZE;
        end else if (exchange) begin
            front_addr_o <= back_addr_o;
            back_addr_o  <= front_addr_o;
            swap_q       <= 1'b1;
            pending_q    <= 1'b0;
        end else begin
            if (swap_req_i) begin
                pending_q <= 1'b1;
            end
            if (swap_q && vsync_i) begin
                swap_q <= 1'b0;
            end
        end
    end

    assign swap_o = swap_q;
    assign busy_o = pending_q | swap_q;

endmodule

//--- rtl/command_unit.sv
/*
 * Command unit. Takes words from the command stream, decodes them and
 * drives the memory writer and buffer swapper. Owns the texture write pointer.
 */

`timescale 1ns/1ns

module command_unit #(
    parameter int FB_WIDTH  = 128,
    parameter int FB_HEIGHT = 128
) (
    input  logic                    clk,
    input  logic                    reset_i,

    input  logic                    cmd_valid_i,
    output logic                    cmd_ready_o,
    input  gfx_cmd_pkg::cmd_word_t  cmd_data_i,

    input  gfx_mem_pkg::vram_addr_t back_addr_i,
    input  logic                    swap_busy_i,
    output logic                    swap_req_o,
    output logic                    swap_wait_vsync_o,

    input  logic                    fill_busy_i,
    output logic                    fill_start_o,
    output gfx_mem_pkg::vram_addr_t fill_addr_o,
    output gfx_mem_pkg::vram_addr_t fill_count_o,
    output gfx_mem_pkg::pixel_t     fill_data_o
);
    import gfx_mem_pkg::*;
    import gfx_cmd_pkg::*;

    localparam vram_addr_t FRAME_SIZE = vram_addr_t'(FB_WIDTH * FB_HEIGHT);
    localparam vram_addr_t DEPTH_ADDR = vram_addr_t'(2 * FB_WIDTH * FB_HEIGHT);

    cmd_state_e state_q;
    cmd_word_t  cmd_q;
    vram_addr_t tex_ptr_q;
    opcode_e    op;

    assign op = opcode_e'(cmd_q.opcode);

    // Stream is only open while nothing is in flight
    assign cmd_ready_o = (state_q == IDLE);

    // Writer and swapper sample these during DECODE only
    assign fill_start_o = (state_q == DECODE) && (op == OP_CLEAR || op == OP_WRITE_TEX);
    assign fill_data_o  = cmd_q.payload;

    always_comb begin
        fill_addr_o  = tex_ptr_q;
        fill_count_o = vram_addr_t'(1);
        if (op == OP_CLEAR) begin
            // Depth region sits after both colour buffers
            fill_addr_o  = cmd_q.select ? DEPTH_ADDR : back_addr_i;
            fill_count_o = FRAME_SIZE;
        end
    end

    assign swap_req_o        = (state_q == DECODE) && (op == OP_SWAP);
    assign swap_wait_vsync_o = cmd_q.payload[0];

    always_ff @(posedge clk) begin
        if (cmd_valid_i && cmd_ready_o) begin
            cmd_q <= cmd_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q   <= IDLE;
            tex_ptr_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (cmd_valid_i) begin
                        state_q <= DECODE;
                    end
                end

                DECODE: begin
                    case (op)
                        OP_CLEAR:     state_q <= FILL;
                        OP_WRITE_TEX: state_q <= TEX_WRITE;
                        OP_SWAP:      state_q <= SWAP_WAIT;
                        OP_SET_TEX_ADDR: begin
                            if (cmd_q.select) begin
                                tex_ptr_q[31:16] <= cmd_q.payload;
                            end else begin
                                tex_ptr_q[15:0] <= cmd_q.payload;
                            end
                            state_q <= IDLE;
                        end
                        default:      state_q <= IDLE;
                    endcase
                end

                FILL: begin
                    if (!fill_busy_i) begin
                        state_q <= IDLE;
                    end
                end

                TEX_WRITE: begin
                    // Pointer moves on once the word is in memory
                    if (!fill_busy_i) begin
                        tex_ptr_q <= tex_ptr_q + vram_addr_t'(1);
                        state_q   <= IDLE;
                    end
                end

                SWAP_WAIT: begin
                    if (!swap_busy_i) begin
                        state_q <= IDLE;
                    end
                end

                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

//--- rtl/graphite_cmd.sv
/*
 * Graphics command front end top level.
 * Ties the command unit to the buffer swapper and the video memory writer.
 */

`timescale 1ns/1ns

module graphite_cmd #(
    parameter int FB_WIDTH  = 128,
    parameter int FB_HEIGHT = 128
) (
    input  logic                    clk,
    input  logic                    reset_i,

    input  logic                    cmd_valid_i,
    output logic                    cmd_ready_o,
    input  gfx_cmd_pkg::cmd_word_t  cmd_data_i,

    output gfx_mem_pkg::vram_req_t  vram_req_o,
    input  logic                    vram_ack_i,

    input  logic                    vsync_i,
    output logic                    swap_o,
    output gfx_mem_pkg::vram_addr_t front_addr_o
);
    import gfx_mem_pkg::*;

    logic       fill_start;
    logic       fill_busy;
    vram_addr_t fill_addr;
    vram_addr_t fill_count;
    pixel_t     fill_data;

    logic       swap_req;
    logic       swap_wait_vsync;
    logic       swap_busy;
    vram_addr_t back_addr;

    command_unit #(
        .FB_WIDTH (FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT)
    ) command_unit_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .cmd_valid_i      (cmd_valid_i),
        .cmd_ready_o      (cmd_ready_o),
        .cmd_data_i       (cmd_data_i),
        .back_addr_i      (back_addr),
        .swap_busy_i      (swap_busy),
        .swap_req_o       (swap_req),
        .swap_wait_vsync_o(swap_wait_vsync),
        .fill_busy_i      (fill_busy),
        .fill_start_o     (fill_start),
        .fill_addr_o      (fill_addr),
        .fill_count_o     (fill_count),
        .fill_data_o      (fill_data)
    );

    buffer_swap #(
        .FB_WIDTH (FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT)
    ) buffer_swap_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .swap_req_i  (swap_req),
        .wait_vsync_i(swap_wait_vsync),
        .vsync_i     (vsync_i),
        .swap_o      (swap_o),
        .busy_o      (swap_busy),
        .front_addr_o(front_addr_o),
        .back_addr_o (back_addr)
    );

    vram_writer vram_writer_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .start_i   (fill_start),
        .addr_i    (fill_addr),
        .count_i   (fill_count),
        .data_i    (fill_data),
        .busy_o    (fill_busy),
        .vram_req_o(vram_req_o),
        .vram_ack_i(vram_ack_i)
    );

endmodule

//--- verif/tb_clock.sv
/*
 * Testbench clock source, free running from time zero.
 */

`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS = 10
) (
    output logic clk_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

//--- verif/graphite_cmd_sva.sv
/*
 * Protocol assertions for the command unit and the video memory writer.
 * Bound into both blocks with the inputs a block lacks tied off.
 */

`timescale 1ns/1ns

module graphite_cmd_sva (
    input logic                      clk,
    input logic                      reset_i,
    input gfx_cmd_pkg::cmd_state_e   state_i,
    input logic                      valid_i,
    input logic                      ready_i,
    input logic                      swap_req_i,
    input logic                      swap_busy_i,
    input gfx_mem_pkg::vram_req_t    req_i,
    input logic                      ack_i
);
    import gfx_cmd_pkg::*;

    // Memory may hold off the ack for any number of cycles
    property req_held_until_ack;
        @(posedge clk) disable iff (reset_i)
            (req_i.select && !ack_i) |=> $stable(req_i);
    endproperty

    // Taking a word leaves IDLE and closes the stream
    property ready_drops_on_accept;
        @(posedge clk) disable iff (reset_i)
            (valid_i && ready_i) |=> (state_i != IDLE) && !ready_i;
    endproperty

    // Busy covers both the swap flag and a pending request
    property no_swap_without_request;
        @(posedge clk) disable iff (reset_i)
            (!swap_busy_i && !swap_req_i) |=> !swap_busy_i;
    endproperty

    assert property (req_held_until_ack)
        else $error("vram request changed before ack");
    assert property (ready_drops_on_accept)
        else $error("cmd_ready_o still high after a word was taken");
    assert property (no_swap_without_request)
        else $error("swap active without a swap request");

endmodule

bind command_unit graphite_cmd_sva cmd_sva_i (
    .clk        (clk),
    .reset_i    (reset_i),
    .state_i    (state_q),
    .valid_i    (cmd_valid_i),
    .ready_i    (cmd_ready_o),
    .swap_req_i (swap_req_o),
    .swap_busy_i(swap_busy_i),
    .req_i      (gfx_mem_pkg::vram_req_t'('0)),
    .ack_i      (1'b0)
);

bind vram_writer graphite_cmd_sva writer_sva_i (
    .clk        (clk),
    .reset_i    (reset_i),
    .state_i    (gfx_cmd_pkg::IDLE),
    .valid_i    (1'b0),
    .ready_i    (1'b1),
    .swap_req_i (1'b0),
    .swap_busy_i(1'b0),
    .req_i      (vram_req_o),
    .ack_i      (vram_ack_i)
);

//--- verif/graphite_cmd_tb.sv
/*
 * Testbench for the graphics command front end. Models video memory with
 * random ack delays and checks fills, texture loads and buffer swaps.
 */

`timescale 1ns/1ns

module graphite_cmd_tb;
    import gfx_mem_pkg::*;
    import gfx_cmd_pkg::*;

    localparam int FB_WIDTH        = 8;
    localparam int FB_HEIGHT       = 4;
    localparam int FRAME_WORDS     = FB_WIDTH * FB_HEIGHT;
    localparam int MEM_WORDS       = 3 * FRAME_WORDS;
    localparam int NUM_CMDS        = 14;
    localparam int WATCHDOG_CYCLES = 40 * FRAME_WORDS * NUM_CMDS;
    localparam int IDLE_LIMIT      = 10 * FRAME_WORDS;
    localparam int TEX_WORDS       = 5;
    localparam logic [15:0] TEX_BASE = 16'd70;

    logic       clk;
    logic       reset_i;
    logic       cmd_valid_i;
    logic       cmd_ready_o;
    cmd_word_t  cmd_data_i;
    vram_req_t  vram_req_o;
    logic       vram_ack_i;
    logic       vsync_i;
    logic       swap_o;
    vram_addr_t front_addr_o;

    pixel_t     mem [MEM_WORDS];
    pixel_t     exp_mem [MEM_WORDS];
    vram_addr_t exp_front;
    vram_addr_t exp_back;
    vram_addr_t exp_tex;
    cmd_word_t  cmd_log [$];

    int          mismatch_count;
    int          timeout_count;
    int          mem_errors;
    logic [31:0] stim_seed;
    logic [31:0] ack_seed;
    int          ack_wait;
    logic        ack_armed;

    // Requests from the stimulus to the comparing process
    int    check_seq;
    int    done_seq;
    string check_label;
    logic  check_image;
    logic  want_ready;
    logic  want_swap;
    int    ref_upto;

    tb_clock #(.PERIOD_NS(10)) clock_i (.clk_o(clk));

    graphite_cmd #(
        .FB_WIDTH (FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT)
    ) dut_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_ready_o (cmd_ready_o),
        .cmd_data_i  (cmd_data_i),
        .vram_req_o  (vram_req_o),
        .vram_ack_i  (vram_ack_i),
        .vsync_i     (vsync_i),
        .swap_o      (swap_o),
        .front_addr_o(front_addr_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic pixel_t fill_pattern(input vram_addr_t addr);
        return pixel_t'(addr[15:0] ^ addr[31:16]) ^ 16'hc3a5;
    endfunction

    function automatic cmd_word_t make_cmd(input logic [7:0] opcode, input logic sel,
                                           input logic [15:0] payload);
        cmd_word_t c;
        c.opcode   = opcode;
        c.reserved = '0;
        c.select   = sel;
        c.payload  = payload;
        return c;
    endfunction

    // Expected memory image and buffer addresses after the first upto commands
    function automatic void build_expected(input int upto);
        vram_addr_t base;
        vram_addr_t tmp;
        cmd_word_t  c;
        for (int a = 0; a < MEM_WORDS; a++) begin
            exp_mem[a] = fill_pattern(vram_addr_t'(a));
        end
        exp_front = '0;
        exp_back  = vram_addr_t'(FRAME_WORDS);
        exp_tex   = '0;
        for (int i = 0; i < upto; i++) begin
            c = cmd_log[i];
            case (opcode_e'(c.opcode))
                OP_CLEAR: begin
                    base = c.select ? vram_addr_t'(2 * FRAME_WORDS) : exp_back;
                    for (int k = 0; k < FRAME_WORDS; k++) begin
                        exp_mem[int'(base) + k] = c.payload;
                    end
                end
                OP_SWAP: begin
                    tmp       = exp_front;
                    exp_front = exp_back;
                    exp_back  = tmp;
                end
                OP_SET_TEX_ADDR: begin
                    if (c.select) begin
                        exp_tex[31:16] = c.payload;
                    end else begin
                        exp_tex[15:0] = c.payload;
                    end
                end
                OP_WRITE_TEX: begin
                    if (exp_tex < vram_addr_t'(MEM_WORDS)) begin
                        exp_mem[int'(exp_tex)] = c.payload;
                    end
                    exp_tex = exp_tex + vram_addr_t'(1);
                end
                default: ;
            endcase
        end
    endfunction

    task automatic check_pixel(input string what, input vram_addr_t addr,
                               input pixel_t got, input pixel_t want);
        if (got !== want) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s word %0d got %h expected %h",
                     $time, what, addr, got, want);
        end
    endtask

    task automatic check_addr(input string what, input vram_addr_t got, input vram_addr_t want);
        if (got !== want) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic want);
        if (got !== want) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, want);
        end
    endtask

    // Comparing process
    initial begin
        forever begin
            @(check_seq);
            if (check_image) begin
                build_expected(cmd_log.size());
                for (int a = 0; a < MEM_WORDS; a++) begin
                    check_pixel(check_label, vram_addr_t'(a), mem[a], exp_mem[a]);
                end
                check_addr({check_label, " front"}, front_addr_o, exp_front);
            end else begin
                build_expected(ref_upto);
                check_flag({check_label, " ready"}, cmd_ready_o, want_ready);
                check_flag({check_label, " swap"}, swap_o, want_swap);
                check_flag({check_label, " select"}, vram_req_o.select, 1'b0);
                check_addr({check_label, " front"}, front_addr_o, exp_front);
            end
            done_seq = check_seq;
        end
    end

    // Memory model, ack comes 0 to 3 cycles after select
    initial begin
        vram_ack_i = 1'b0;
        ack_armed  = 1'b0;
        ack_wait   = 0;
        ack_seed   = 32'd71;
        forever begin
            @(negedge clk);
            if (reset_i || vram_ack_i) begin
                vram_ack_i = 1'b0;
                ack_armed  = 1'b0;
            end else if (vram_req_o.select) begin
                if (!ack_armed) begin
                    ack_seed  = lcg_next(ack_seed);
                    ack_wait  = int'(ack_seed[17:16]);
                    ack_armed = 1'b1;
                end
                if (ack_wait == 0) begin
                    vram_ack_i = 1'b1;
                end else begin
                    ack_wait--;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (reset_i) begin
            for (int a = 0; a < MEM_WORDS; a++) begin
                mem[a] <= fill_pattern(vram_addr_t'(a));
            end
        end else if (vram_req_o.select && vram_req_o.write && vram_ack_i) begin
            if (vram_req_o.address < vram_addr_t'(MEM_WORDS)) begin
                mem[int'(vram_req_o.address)] <= vram_req_o.data;
            end else begin
                mem_errors++;
                $display("Write outside the memory model at address %h", vram_req_o.address);
            end
        end
    end

    task automatic compare_image(input string label);
        check_label = label;
        check_image = 1'b1;
        check_seq++;
        wait (done_seq == check_seq);
    endtask

    task automatic compare_signals(input string label, input logic ready, input logic swap,
                                   input int upto);
        check_label = label;
        check_image = 1'b0;
        want_ready  = ready;
        want_swap   = swap;
        ref_upto    = upto;
        check_seq++;
        wait (done_seq == check_seq);
    endtask

    task automatic wait_ready(input string what);
        int n;
        n = 0;
        while (cmd_ready_o !== 1'b1 && n < IDLE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (cmd_ready_o !== 1'b1) begin
            timeout_count++;
            $display("Timeout: command stream never became ready during %s", what);
        end
    endtask

    task automatic send_cmd(input cmd_word_t cmd);
        wait_ready("command issue");
        cmd_valid_i = 1'b1;
        cmd_data_i  = cmd;
        @(negedge clk);
        cmd_valid_i = 1'b0;
        cmd_log.push_back(cmd);
    endtask

    task automatic run_cmd(input cmd_word_t cmd);
        send_cmd(cmd);
        wait_ready("command execution");
    endtask

    task automatic wait_swap(input string what);
        int n;
        n = 0;
        while (swap_o !== 1'b1 && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (swap_o !== 1'b1) begin
            timeout_count++;
            $display("Timeout: swap_o never rose during %s", what);
        end
    endtask

    task automatic pulse_vsync();
        vsync_i = 1'b1;
        @(negedge clk);
        vsync_i = 1'b0;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    initial begin
        reset_i     = 1'b1;
        cmd_valid_i = 1'b0;
        cmd_data_i  = '0;
        vsync_i     = 1'b0;
        stim_seed   = 32'd71;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        compare_signals("after reset", 1'b1, 1'b0, 0);

        run_cmd(make_cmd(OP_CLEAR, 1'b0, 16'h1111));
        compare_image("colour clear");
        run_cmd(make_cmd(OP_CLEAR, 1'b1, 16'h2222));
        compare_image("depth clear");

        // High half first, then cleared again to land inside the model
        run_cmd(make_cmd(OP_SET_TEX_ADDR, 1'b1, 16'h0001));
        run_cmd(make_cmd(OP_SET_TEX_ADDR, 1'b0, TEX_BASE));
        run_cmd(make_cmd(OP_SET_TEX_ADDR, 1'b1, 16'h0000));
        for (int i = 0; i < TEX_WORDS; i++) begin
            stim_seed = lcg_next(stim_seed);
            run_cmd(make_cmd(OP_WRITE_TEX, 1'b0, stim_seed[23:8]));
        end
        run_cmd(make_cmd(8'h7f, 1'b1, 16'hdead));
        compare_image("texture writes");

        send_cmd(make_cmd(OP_SWAP, 1'b0, 16'h0000));
        wait_swap("no-wait swap");
        compare_signals("no-wait swap", 1'b0, 1'b1, cmd_log.size());
        repeat (3) @(negedge clk);
        compare_signals("swap held", 1'b0, 1'b1, cmd_log.size());
        pulse_vsync();
        wait_ready("no-wait swap");
        compare_signals("after vsync", 1'b1, 1'b0, cmd_log.size());
        run_cmd(make_cmd(OP_CLEAR, 1'b0, 16'h3333));
        compare_image("clear after swap");

        send_cmd(make_cmd(OP_SWAP, 1'b0, 16'h0001));
        repeat (10) begin
            @(negedge clk);
            compare_signals("swap waiting", 1'b0, 1'b0, cmd_log.size() - 1);
        end
        pulse_vsync();
        compare_signals("swap at vsync", 1'b0, 1'b1, cmd_log.size());
        pulse_vsync();
        wait_ready("vsync swap");
        compare_signals("vsync swap done", 1'b1, 1'b0, cmd_log.size());
        compare_image("final image");

        $display("Run complete: %0d mismatches, %0d timeouts, %0d memory errors",
                 mismatch_count, timeout_count, mem_errors);
        if (mismatch_count + timeout_count + mem_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- graphite_cmd.f
rtl/gfx_mem_pkg.sv
rtl/gfx_cmd_pkg.sv
rtl/vram_writer.sv
rtl/buffer_swap.sv
rtl/command_unit.sv
rtl/graphite_cmd.sv
verif/tb_clock.sv
verif/graphite_cmd_sva.sv
verif/graphite_cmd_tb.sv

//--- Makefile
# Verilator flow for the graphics command front end

VERILATOR ?= verilator
TOP       ?= graphite_cmd_tb
RTL_TOP   ?= graphite_cmd
FILELIST  ?= graphite_cmd.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Everything OK
VFLAGS    ?=
RTL_SRCS  ?= rtl/gfx_mem_pkg.sv rtl/gfx_cmd_pkg.sv rtl/vram_writer.sv \
             rtl/buffer_swap.sv rtl/command_unit.sv rtl/graphite_cmd.sv
TB_SRCS   ?= verif/tb_clock.sv verif/graphite_cmd_sva.sv verif/graphite_cmd_tb.sv

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST) $(VFLAGS)

sim: build
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
